//--- hw/MapperPkg.sv
package MapperPkg;

    // ============================================================
    // Host bus and backend port widths
    // ============================================================
    localparam int HostAddrWidth = 16;
    localparam int DataWidth = 8;
    // Up to 512 ROM banks of 16 KiB and 16 RAM banks of 8 KiB
    localparam int RomBankWidth = 9;
    localparam int RamBankWidth = 4;
    localparam int RomAddrWidth = 23;
    localparam int RamAddrWidth = 17;
    localparam int RomOffsetWidth = 14;
    localparam int RamOffsetWidth = 13;
    // Pending backend acknowledges, tops out at all ones
    localparam int OutstandingWidth = 5;

    // ============================================================
    // Boot configuration page at $FExx
    // ============================================================
    localparam logic [7:0] ConfigPage = 8'hFE;
    localparam logic [7:0] CfgKindOffset = 8'hA0;
    localparam logic [7:0] CfgRomMaskLoOffset = 8'hA3;
    localparam logic [7:0] CfgRomMaskHiOffset = 8'hA4;
    localparam logic [7:0] CfgRamMaskOffset = 8'hA5;
    localparam logic [7:0] CfgFeaturesOffset = 8'hA6;
    // Nonzero here freezes the page until reset
    localparam logic [7:0] CfgLockOffset = 8'h50;

    // Low nibble that turns cartridge RAM on
    localparam logic [3:0] RamEnableKey = 4'hA;
    // Returned by register reads and unmapped space
    localparam logic [DataWidth-1:0] OpenBusData = 8'hFF;

    typedef enum logic [2:0] {
        MapRom = 3'd0,
        MapMbc1 = 3'd1,
        MapMbc2 = 3'd2,
        MapMbc3 = 3'd3,
        MapMbc5 = 3'd4
    } MapperKind;

endpackage

//--- hw/MapperIfs.sv
`timescale 1ns/1ps

// Register write strobes, one cycle wide, from the bus router
interface RegWriteIf
    import MapperPkg::*;
();
    logic cfgWrite;
    logic bankWrite;
    logic [HostAddrWidth-1:0] addr;
    logic [DataWidth-1:0] data;

    modport source (output cfgWrite, bankWrite, addr, data);
    modport sink (input cfgWrite, bankWrite, addr, data);
endinterface

// Cartridge description, fixed once the boot code locks it
interface ConfigIf
    import MapperPkg::*;
();
    MapperKind kind;
    logic [RomBankWidth-1:0] romMask;
    logic [RamBankWidth-1:0] ramMask;
    logic hasRam;

    modport source (output kind, romMask, ramMask, hasRam);
    modport reader (input kind, romMask, ramMask, hasRam);
endinterface

// Live MBC register state
interface BankStateIf
    import MapperPkg::*;
();
    logic [RomBankWidth-1:0] romBankId;
    logic [RamBankWidth-1:0] ramBankId;
    logic bankingMode;
    logic ramEnabled;

    modport source (output romBankId, ramBankId, bankingMode, ramEnabled);
    modport reader (input romBankId, ramBankId, bankingMode, ramEnabled);
endinterface

//--- hw/MapperConfig.sv
`timescale 1ns/1ps

module MapperConfig
    import MapperPkg::*;
(
    input logic SysCon,
    input logic rst,
    RegWriteIf.sink regs,
    ConfigIf.source cfg
);
    MapperKind kind;
    logic [RomBankWidth-1:0] romMask;
    logic [RamBankWidth-1:0] ramMask;
    logic hasRam;
    logic locked;

    // Defaults expose a plain 32 KiB ROM so boot code can read the header
    always_ff @(posedge SysCon)
    begin
        if (rst)
        begin
            kind <= MapRom;
            romMask <= '1;
            ramMask <= '1;
            hasRam <= 1'b0;
            locked <= 1'b0;
        end
        else if (regs.cfgWrite && !locked)
        begin
            // Router already matched the $FE page, decode the low byte only
            case (regs.addr[7:0])
                CfgKindOffset:
                    kind <= MapperKind'(regs.data[2:0]);
                CfgRomMaskLoOffset:
                    romMask[7:0] <= regs.data;
                CfgRomMaskHiOffset:
                    romMask[8] <= regs.data[0];
                CfgRamMaskOffset:
                    ramMask <= regs.data[RamBankWidth-1:0];
                CfgFeaturesOffset:
                    hasRam <= regs.data[0];
                CfgLockOffset:
                    locked <= (regs.data != '0);
                default:
                    locked <= locked;
            endcase
        end
    end

    assign cfg.kind = kind;
    assign cfg.romMask = romMask;
    assign cfg.ramMask = ramMask;
    assign cfg.hasRam = hasRam;

    // Cartridge description frozen for the rest of the session
    assert property (@(posedge SysCon) disable iff (rst)
        locked |=> $stable({cfg.kind, cfg.romMask, cfg.ramMask, cfg.hasRam}))
    else $error("Configuration page changed while locked");

endmodule

//--- hw/BankRegisters.sv
`timescale 1ns/1ps

module BankRegisters
    import MapperPkg::*;
(
    input logic SysCon,
    input logic rst,
    RegWriteIf.sink regs,
    ConfigIf.reader cfg,
    BankStateIf.source bank
);
    logic [RomBankWidth-1:0] romBankId;
    logic [RamBankWidth-1:0] ramBankId;
    logic bankingMode;
    logic ramEnabled;
    // Low bank byte after masking, then with the bank-0 fixup
    logic [7:0] maskedLow;
    logic [7:0] lowBits;
    // MBC5 upper half of the $2000 window holds bank bit 8
    logic highWrite;
    logic keyMatch;

    assign maskedLow = regs.data & cfg.romMask[7:0];
    // Only MBC5 may map bank 0 into the upper window
    assign lowBits = (maskedLow == '0 && cfg.kind != MapMbc5) ? 8'd1 : maskedLow;
    assign highWrite = (cfg.kind == MapMbc5) && regs.addr[12];
    assign keyMatch = (regs.data[3:0] == RamEnableKey);

    always_ff @(posedge SysCon)
    begin
        if (rst)
        begin
            romBankId <= 9'd1;
            ramBankId <= '0;
            bankingMode <= 1'b0;
            ramEnabled <= 1'b0;
        end
        // Plain ROM carts have no registers
        else if (regs.bankWrite && cfg.kind != MapRom)
        begin
            if (cfg.kind == MapMbc2 && !regs.addr[14])
            begin
                // MBC2 splits all of $0000-$3FFF on address bit 8
                if (regs.addr[8])
                    romBankId[7:0] <= lowBits;
                else
                    ramEnabled <= keyMatch;
            end
            else
            begin
                // Address bits 14-13 pick one of four 8 KiB register windows
                case (regs.addr[14:13])
                    2'b00:
                        ramEnabled <= keyMatch;
                    2'b01:
                        if (highWrite)
                            romBankId[8] <= regs.data[0] & cfg.romMask[8];
                        else
                            romBankId[7:0] <= lowBits;
                    2'b10:
                        ramBankId <= regs.data[RamBankWidth-1:0];
                    default:
                        bankingMode <= regs.data[0];
                endcase
            end
        end
    end

    assign bank.romBankId = romBankId;
    assign bank.ramBankId = ramBankId;
    assign bank.bankingMode = bankingMode;
    assign bank.ramEnabled = ramEnabled;

    // Upper window never falls back onto bank 0 outside MBC5
    assert property (@(posedge SysCon) disable iff (rst)
        (cfg.kind != MapMbc5) |-> (romBankId != '0))
    else $error("ROM bank 0 selected on a mapper that forbids it");

endmodule

//--- hw/AddressTranslate.sv
`timescale 1ns/1ps

module AddressTranslate
    import MapperPkg::*;
(
    input logic [HostAddrWidth-1:0] addr,
    ConfigIf.reader cfg,
    BankStateIf.reader bank,
    output logic [RomAddrWidth-1:0] romAddr,
    output logic [RamAddrWidth-1:0] ramAddr,
    output logic ramAllowed
);
    logic [RomBankWidth-1:0] upperBank;
    logic [RomBankWidth-1:0] lowerBank;
    logic [RamBankWidth-1:0] ramBank;
    // MBC1 mode 1 on a 1 MiB or larger image
    logic mbc1Large;

    assign mbc1Large = bank.bankingMode && cfg.romMask[5];

    always_comb
    begin
        // Plain ROM layout, banks 0 and 1 fixed
        upperBank = 9'd1;
        lowerBank = '0;
        ramBank = bank.ramBankId & cfg.ramMask;
        case (cfg.kind)
            MapMbc1:
            begin
                upperBank = {4'b0000, bank.romBankId[4:0] & cfg.romMask[4:0]};
                // Secondary 2-bit register drives bank bits 6-5 in both windows
                if (mbc1Large)
                begin
                    upperBank[6:5] = bank.ramBankId[1:0];
                    lowerBank[6:5] = bank.ramBankId[1:0];
                end
                // RAM banking only in mode 1 on small ROMs
                if (!bank.bankingMode || cfg.romMask[5])
                    ramBank = '0;
            end
            MapMbc2, MapMbc3, MapMbc5:
                upperBank = bank.romBankId & cfg.romMask;
            default:
                upperBank = 9'd1;
        endcase
    end

    // Address bit 14 picks the switchable $4000-$7FFF window
    assign romAddr = {addr[14] ? upperBank : lowerBank, addr[RomOffsetWidth-1:0]};
    assign ramAddr = {ramBank, addr[RamOffsetWidth-1:0]};
    assign ramAllowed = bank.ramEnabled && cfg.hasRam;

endmodule

//--- hw/BusRouter.sv
`timescale 1ns/1ps

module BusRouter
    import MapperPkg::*;
(
    input logic SysCon,
    input logic rst,
    // Host side
    input logic cyc,
    input logic stb,
    input logic we,
    input logic [HostAddrWidth-1:0] addr,
    input logic [DataWidth-1:0] datIn,
    output logic stall,
    output logic ack,
    output logic [DataWidth-1:0] datOut,
    // ROM image port, read only
    output logic romCyc,
    output logic romStb,
    output logic [RomAddrWidth-1:0] romAddr,
    input logic romStall,
    input logic romAck,
    input logic [DataWidth-1:0] romDat,
    // Cartridge RAM port
    output logic ramCyc,
    output logic ramStb,
    output logic ramWe,
    output logic [RamAddrWidth-1:0] ramAddr,
    output logic [DataWidth-1:0] ramDatOut,
    input logic ramStall,
    input logic ramAck,
    input logic [DataWidth-1:0] ramDat,
    // Translated addresses for the current host request
    input logic [RomAddrWidth-1:0] mappedRomAddr,
    input logic [RamAddrWidth-1:0] mappedRamAddr,
    input logic ramAllowed,
    RegWriteIf.source regs
);
    logic isRomRead;
    logic isBankWrite;
    logic isCfgWrite;
    logic isRamAccess;
    logic isInternal;
    logic backendStall;
    logic switchStall;
    logic accept;
    logic issue;
    logic retire;
    logic romAckIn;
    logic ramAckIn;
    logic [OutstandingWidth-1:0] pending;
    logic pendingBusy;
    // Backend that owns the pending acknowledges
    logic curRam;
    logic intAck;

    // ============================================================
    // Request classification
    // ============================================================
    assign isRomRead = !addr[15] && !we;
    assign isBankWrite = !addr[15] && we;
    assign isCfgWrite = (addr[15:8] == ConfigPage) && we;
    // Disabled RAM falls through to the open-bus path
    assign isRamAccess = (addr[15:13] == 3'b101) && ramAllowed;
    assign isInternal = !isRomRead && !isRamAccess;

    // ============================================================
    // Stall and acceptance
    // ============================================================
    assign pendingBusy = (pending != '0);
    // Held downstream request still waiting on the backend
    assign backendStall = isRamAccess ? (ramStb && ramStall) : (romStb && romStall);
    // Internal replies and backend switches wait for all pending acks
    assign switchStall = pendingBusy && (isInternal || (curRam != isRamAccess));
    assign stall = switchStall || (!isInternal && (backendStall || (&pending)));

    assign accept = cyc && stb && !stall;
    assign issue = accept && !isInternal;
    assign romAckIn = romAck && romCyc;
    assign ramAckIn = ramAck && ramCyc;
    assign retire = romAckIn || ramAckIn;

    // Pending acknowledge counter
    always_ff @(posedge SysCon)
    begin
        if (rst)
            pending <= '0;
        else
        begin
            case ({issue, retire})
                2'b10:
                    pending <= pending + 1'b1;
                2'b01:
                    pending <= pending - 1'b1;
                default:
                    pending <= pending;
            endcase
        end
    end

    // Downstream strobes, dropped once the backend takes the request
    always_ff @(posedge SysCon)
    begin
        if (rst)
        begin
            romStb <= 1'b0;
            ramStb <= 1'b0;
            curRam <= 1'b0;
        end
        else
        begin
            if (romStb && !romStall)
                romStb <= 1'b0;
            if (ramStb && !ramStall)
                ramStb <= 1'b0;
            if (issue)
            begin
                romStb <= !isRamAccess;
                ramStb <= isRamAccess;
                curRam <= isRamAccess;
            end
        end
    end

    // Request payloads
    always_ff @(posedge SysCon)
    begin
        if (issue && !isRamAccess)
            romAddr <= mappedRomAddr;
        if (issue && isRamAccess)
        begin
            ramAddr <= mappedRamAddr;
            ramWe <= we;
            ramDatOut <= datIn;
        end
        if (accept && isInternal)
        begin
            regs.addr <= addr;
            regs.data <= datIn;
        end
    end

    // Internal path, acknowledged one cycle after acceptance
    always_ff @(posedge SysCon)
    begin
        if (rst)
        begin
            intAck <= 1'b0;
            regs.cfgWrite <= 1'b0;
            regs.bankWrite <= 1'b0;
        end
        else
        begin
            intAck <= accept && isInternal;
            regs.cfgWrite <= accept && isCfgWrite;
            regs.bankWrite <= accept && isBankWrite;
        end
    end

    // Cycle stays open until the owning backend has answered everything
    assign romCyc = romStb || (pendingBusy && !curRam);
    assign ramCyc = ramStb || (pendingBusy && curRam);

    // Backend acks pass straight through to the host
    assign ack = intAck || retire;
    assign datOut = romAckIn ? romDat : (ramAckIn ? ramDat : OpenBusData);

    assert property (@(posedge SysCon) disable iff (rst) !(romCyc && ramCyc))
    else $error("ROM and RAM cycles open together");

    // Every backend ack must match an issued request
    assert property (@(posedge SysCon) disable iff (rst) retire |-> pendingBusy)
    else $error("Backend acknowledge with no request outstanding");

endmodule

//--- hw/GbcMapper.sv
`timescale 1ns/1ps

module GbcMapper
    import MapperPkg::*;
(
    input logic SysCon,
    input logic rst,
    // Host bus
    input logic cyc,
    input logic stb,
    input logic we,
    input logic [HostAddrWidth-1:0] addr,
    input logic [DataWidth-1:0] datIn,
    output logic stall,
    output logic ack,
    output logic [DataWidth-1:0] datOut,
    // ROM image
    output logic romCyc,
    output logic romStb,
    output logic [RomAddrWidth-1:0] romAddr,
    input logic romStall,
    input logic romAck,
    input logic [DataWidth-1:0] romDat,
    // Cartridge RAM
    output logic ramCyc,
    output logic ramStb,
    output logic ramWe,
    output logic [RamAddrWidth-1:0] ramAddr,
    output logic [DataWidth-1:0] ramDatOut,
    input logic ramStall,
    input logic ramAck,
    input logic [DataWidth-1:0] ramDat
);
    // Combinational translation of the live host address
    logic [RomAddrWidth-1:0] mappedRomAddr;
    logic [RamAddrWidth-1:0] mappedRamAddr;
    logic ramAllowed;

    RegWriteIf regWrite();
    ConfigIf cfgBus();
    BankStateIf bankState();

    BusRouter router (
        .SysCon(SysCon), .rst(rst),
        .cyc(cyc), .stb(stb), .we(we), .addr(addr), .datIn(datIn),
        .stall(stall), .ack(ack), .datOut(datOut),
        .romCyc(romCyc), .romStb(romStb), .romAddr(romAddr),
        .romStall(romStall), .romAck(romAck), .romDat(romDat),
        .ramCyc(ramCyc), .ramStb(ramStb), .ramWe(ramWe), .ramAddr(ramAddr),
        .ramDatOut(ramDatOut), .ramStall(ramStall), .ramAck(ramAck), .ramDat(ramDat),
        .mappedRomAddr(mappedRomAddr), .mappedRamAddr(mappedRamAddr),
        .ramAllowed(ramAllowed), .regs(regWrite)
    );

    MapperConfig cfgPage (.SysCon(SysCon), .rst(rst), .regs(regWrite), .cfg(cfgBus));

    BankRegisters bankRegs (
        .SysCon(SysCon), .rst(rst), .regs(regWrite), .cfg(cfgBus), .bank(bankState)
    );

    AddressTranslate translate (
        .addr(addr), .cfg(cfgBus), .bank(bankState),
        .romAddr(mappedRomAddr), .ramAddr(mappedRamAddr), .ramAllowed(ramAllowed)
    );

endmodule

//--- test/GbcMapperTb.sv
`timescale 1ns/1ps

module GbcMapperTb
    import MapperPkg::*;
();
    // ============================================================
    // DUT signals
    // ============================================================
    logic SysCon = 1'b0;
    logic rst;
    logic cyc;
    logic stb;
    logic we;
    logic [HostAddrWidth-1:0] addr;
    logic [DataWidth-1:0] datIn;
    logic stall;
    logic ack;
    logic [DataWidth-1:0] datOut;
    logic romCyc;
    logic romStb;
    logic [RomAddrWidth-1:0] romAddr;
    logic romStall = 1'b0;
    logic romAck = 1'b0;
    logic [DataWidth-1:0] romDat = '0;
    logic ramCyc;
    logic ramStb;
    logic ramWe;
    logic [RamAddrWidth-1:0] ramAddr;
    logic [DataWidth-1:0] ramDatOut;
    logic ramStall = 1'b0;
    logic ramAck = 1'b0;
    logic [DataWidth-1:0] ramDat = '0;

    // Backend model state
    integer seed = 43;
    int romWait = 0;
    int ramWait = 0;
    logic [DataWidth-1:0] romQueue[$];
    logic [DataWidth-1:0] ramQueue[$];
    logic [DataWidth-1:0] ramMem [0:(1 << RamAddrWidth) - 1];

    // Stimulus table, one entry per data line
    int testNum[$];
    logic [7:0] opCode[$];
    logic [HostAddrWidth-1:0] addrList[$];
    logic [DataWidth-1:0] dataList[$];
    logic [DataWidth-1:0] expList[$];
    int lineCount = 0;
    bit loaded = 1'b0;

    // Bookkeeping
    int testErrors = 0;
    int passCount = 0;
    int failCount = 0;

    GbcMapper uut (
        .SysCon(SysCon), .rst(rst),
        .cyc(cyc), .stb(stb), .we(we), .addr(addr), .datIn(datIn),
        .stall(stall), .ack(ack), .datOut(datOut),
        .romCyc(romCyc), .romStb(romStb), .romAddr(romAddr),
        .romStall(romStall), .romAck(romAck), .romDat(romDat),
        .ramCyc(ramCyc), .ramStb(ramStb), .ramWe(ramWe), .ramAddr(ramAddr),
        .ramDatOut(ramDatOut), .ramStall(ramStall), .ramAck(ramAck), .ramDat(ramDat)
    );

    // 40 ns period
    always #20 SysCon = ~SysCon;

    // ============================================================
    // Backend models with random stall and ack delay
    // ============================================================
    initial
    begin
        for (int i = 0; i < (1 << RamAddrWidth); i++)
            ramMem[i] = '0;
    end

    always @(posedge SysCon)
    begin
        romAck <= 1'b0;
        ramAck <= 1'b0;
        // Roughly one cycle in four stalled
        romStall <= ($unsigned($random(seed)) % 4) == 0;
        ramStall <= ($unsigned($random(seed)) % 4) == 0;

        // Oldest ROM request answers once its delay runs out
        if (romQueue.size() > 0)
        begin
            if (romWait == 0)
            begin
                romAck <= 1'b1;
                romDat <= romQueue.pop_front();
                romWait <= $unsigned($random(seed)) % 4;
            end
            else
                romWait <= romWait - 1;
        end
        // ROM image pattern is bank byte XOR low address byte
        if (romCyc && romStb && !romStall)
            romQueue.push_back(romAddr[21:14] ^ romAddr[7:0]);

        if (ramQueue.size() > 0)
        begin
            if (ramWait == 0)
            begin
                ramAck <= 1'b1;
                ramDat <= ramQueue.pop_front();
                ramWait <= $unsigned($random(seed)) % 4;
            end
            else
                ramWait <= ramWait - 1;
        end
        // Writes echo the stored byte on their ack
        if (ramCyc && ramStb && !ramStall)
        begin
            if (ramWe)
            begin
                ramMem[ramAddr] <= ramDatOut;
                ramQueue.push_back(ramDatOut);
            end
            else
                ramQueue.push_back(ramMem[ramAddr]);
        end
    end

    // Only one backend may own the bus at a time
    always @(negedge SysCon)
    begin
        if (!rst && romCyc && ramCyc)
        begin
            $display("ERROR: ROM and RAM cycles are open at the same time at %0t", $time);
            testErrors++;
        end
    end

    // ============================================================
    // Helpers
    // ============================================================
    function automatic string testName(input int num);
        case (num)
            1: return "reset defaults";
            2: return "config lock";
            3: return "mbc1 banking";
            4: return "mbc5 and mbc2";
            5: return "cartridge ram";
            6: return "back-pressure";
            default: return "unnamed";
        endcase
    endfunction

    task automatic compareByte(input string name, input logic [7:0] expected,
                               input logic [7:0] actual);
        if (actual !== expected)
        begin
            $display("FAILED %s: expected %02h, actual %02h", name, expected, actual);
            testErrors++;
        end
    endtask

    task automatic applyReset();
        rst <= 1'b1;
        repeat (8) @(posedge SysCon);
        rst <= 1'b0;
    endtask

    // One host write, held until accepted, then wait for its ack
    task automatic writeAccess(input logic [HostAddrWidth-1:0] a,
                               input logic [DataWidth-1:0] d,
                               output logic [DataWidth-1:0] result);
        @(posedge SysCon);
        cyc <= 1'b1;
        stb <= 1'b1;
        we <= 1'b1;
        addr <= a;
        datIn <= d;
        @(negedge SysCon);
        while (stall)
            @(negedge SysCon);
        // Taken on this edge
        @(posedge SysCon);
        stb <= 1'b0;
        @(negedge SysCon);
        while (!ack)
            @(negedge SysCon);
        result = datOut;
        @(posedge SysCon);
        cyc <= 1'b0;
        we <= 1'b0;
    endtask

    // Run of reads issued back to back, acks checked in request order
    task automatic readBurst(input int first, input int count);
        int issued;
        int received;
        logic accepted;
        issued = 0;
        received = 0;
        @(posedge SysCon);
        cyc <= 1'b1;
        stb <= 1'b1;
        we <= 1'b0;
        addr <= addrList[first];
        while (received < count)
        begin
            @(negedge SysCon);
            if (ack)
            begin
                compareByte($sformatf("%s read %04h", testName(testNum[first + received]),
                                      addrList[first + received]),
                            expList[first + received], datOut);
                received++;
            end
            // Held request is taken at the next edge unless stalled
            accepted = stb && !stall;
            @(posedge SysCon);
            if (accepted)
            begin
                issued++;
                if (issued < count)
                    addr <= addrList[first + issued];
                else
                    stb <= 1'b0;
            end
        end
        cyc <= 1'b0;
    endtask

    task automatic finishTest(input int num);
        if (testErrors == 0)
        begin
            $display("Test %0d (%s): passed", num, testName(num));
            passCount++;
        end
        else
        begin
            $display("Test %0d (%s): failed with %0d errors", num, testName(num), testErrors);
            failCount++;
        end
    endtask

    // ============================================================
    // Stimulus
    // ============================================================
    initial
    begin
        string line;
        int fd;
        int num;
        int prevTest;
        int i;
        int last;
        logic [7:0] code;
        logic [HostAddrWidth-1:0] a;
        logic [DataWidth-1:0] d;
        logic [DataWidth-1:0] e;
        logic [DataWidth-1:0] result;

        rst = 1'b1;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        addr = '0;
        datIn = '0;

        fd = $fopen("test/mapper_testdata.txt", "r");
        if (fd == 0)
            $display("ERROR: cannot open test/mapper_testdata.txt");
        else
        begin
            while (!$feof(fd))
            begin
                line = "";
                void'($fgets(line, fd));
                // Comment and blank lines do not parse
                if ($sscanf(line, "%d %c %h %h %h", num, code, a, d, e) == 5)
                begin
                    testNum.push_back(num);
                    opCode.push_back(code);
                    addrList.push_back(a);
                    dataList.push_back(d);
                    expList.push_back(e);
                end
            end
            $fclose(fd);
        end
        lineCount = testNum.size();
        if (lineCount > 0)
            loaded = 1'b1;
        else
            $display("ERROR: no stimulus lines were read");

        applyReset();

        prevTest = -1;
        i = 0;
        while (i < lineCount)
        begin
            if (testNum[i] != prevTest)
            begin
                if (prevTest >= 0)
                    finishTest(prevTest);
                prevTest = testNum[i];
                testErrors = 0;
            end
            case (opCode[i])
                "X":
                begin
                    applyReset();
                    i++;
                end
                "W":
                begin
                    writeAccess(addrList[i], dataList[i], result);
                    compareByte($sformatf("%s write %04h", testName(testNum[i]), addrList[i]),
                                expList[i], result);
                    i++;
                end
                default:
                begin
                    // Neighbouring reads of one test share a pipelined burst
                    last = i;
                    while (last + 1 < lineCount && opCode[last + 1] != "W"
                           && opCode[last + 1] != "X" && testNum[last + 1] == testNum[i])
                        last++;
                    readBurst(i, last - i + 1);
                    i = last + 1;
                end
            endcase
        end
        if (prevTest >= 0)
            finishTest(prevTest);

        $display("Tests run: %0d, passed: %0d, failed: %0d",
                 passCount + failCount, passCount, failCount);
        if (failCount == 0 && lineCount > 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

    // Watchdog scaled by the number of accesses
    initial
    begin
        wait (loaded);
        repeat (lineCount * 200) @(posedge SysCon);
        $display("ERROR: watchdog expired, the DUT stopped answering requests");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

//--- GbcMapper.f
hw/MapperPkg.sv
hw/MapperIfs.sv
hw/MapperConfig.sv
hw/BankRegisters.sv
hw/AddressTranslate.sv
hw/BusRouter.sv
hw/GbcMapper.sv
test/GbcMapperTb.sv

//--- run.sh
#!/bin/bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module GbcMapperTb \
    -f GbcMapper.f -o GbcMapperSim
./obj_dir/GbcMapperSim | tee sim.log

if grep -q "^ALL TESTS PASSED$" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi

//--- test/mapper_testdata.txt
# test op(R read, W write, X re-reset) addr data expected
# ROM bytes are bank[7:0] XOR addr[7:0], RAM writes return the stored byte
1 R 4123 00 22
1 R 0123 00 23
1 R C000 00 FF
2 W FEA0 01 FF
2 W FEA3 1F FF
2 W FE50 01 FF
2 W FEA0 04 FF
2 W 2000 00 FF
2 R 4123 00 22
3 X 0000 00 00
3 W FEA0 01 FF
3 W FEA3 0F FF
3 W 2000 00 FF
3 R 4000 00 01
3 W 2000 13 FF
3 R 4055 00 56
3 W FEA3 3F FF
3 W 2000 07 FF
3 W 6000 01 FF
3 W 4000 02 FF
3 R 4033 00 74
3 R 0033 00 73
4 X 0000 00 00
4 W FEA0 04 FF
4 W 2000 05 FF
4 W 3000 01 FF
4 R 4012 00 17
4 W 2000 00 FF
4 W 3000 00 FF
4 R 4012 00 12
4 X 0000 00 00
4 W FEA0 02 FF
4 W 2100 03 FF
4 R 4012 00 11
4 W 2000 05 FF
4 R 4012 00 11
4 W 0100 07 FF
4 R 4020 00 27
5 X 0000 00 00
5 W FEA0 03 FF
5 R A000 00 FF
5 W A000 5A FF
5 W 0000 0A FF
5 R A000 00 FF
5 W FEA6 01 FF
5 R A000 00 00
5 W A000 5A 5A
5 W 4000 01 FF
5 W A000 C3 C3
5 R A000 00 C3
5 W 4000 00 FF
5 R A000 00 5A
6 R 4012 00 13
6 R A000 00 5A
6 R 0077 00 77
6 R A001 00 00
6 R 40FF 00 FE
6 W 4000 01 FF
6 R A000 00 C3
6 R 4034 00 35
